//--- pcs_rx_defs.svh
// width, lock threshold and scrambler tap macros for the pcs receive path
`ifndef PCS_RX_DEFS_SVH
`define PCS_RX_DEFS_SVH

// block layout
`define PCS_HEAD_W 2
`define PCS_DATA_W 64
`define PCS_BLOCK_W 66

// block lock thresholds, counted in blocks
`define PCS_LOCK_GOOD 64
`define PCS_BAD_MAX 16
`define PCS_SLIP_WAIT 4

// self-synchronous scrambler x^58 + x^39 + 1
`define PCS_SCR_LEN 58
`define PCS_SCR_TAP_A 39
`define PCS_SCR_TAP_B 58

`endif

//--- pcs_rx_pkg.sv
// shared sync header, payload and block types with the valid header constants
`include "pcs_rx_defs.svh"

package pcs_rx_pkg;

	// 2-bit sync header, bit 0 goes first on the line
	typedef logic [`PCS_HEAD_W-1:0] sync_head_t;

	// scrambled or plain 64-bit payload
	typedef logic [`PCS_DATA_W-1:0] payload_t;

	// whole block, header in the low bits since it is sent first
	typedef struct packed {
		payload_t   data;
		sync_head_t head;
	} block_t;

	// only these two headers are legal
	localparam sync_head_t HEAD_DATA = 2'b01;
	localparam sync_head_t HEAD_CTRL = 2'b10;

endpackage

//--- gearbox_rx.sv
// rx gearbox from 64-bit serdes words to 66-bit blocks, with a one-bit slip
`include "pcs_rx_defs.svh"

module gearbox_rx
	import pcs_rx_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,

	input  payload_t   data_i,
	input  logic       slip_i,

	output logic       valid_o,
	output sync_head_t head_o,
	output payload_t   data_o
);
	localparam int BLOCK_W = `PCS_BLOCK_W;
	localparam int DATA_W = `PCS_DATA_W;
	// worst case is 65 leftover bits plus a full word
	localparam int BUF_W = BLOCK_W + DATA_W;
	localparam int CNT_W = $clog2(BUF_W + 1);

	// residue buffer with the oldest bit at index 0
	logic [BUF_W-1:0] buf_q;
	logic [BUF_W-1:0] buf_next;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_next;

	logic [BUF_W-1:0] keep_mask;
	logic [BUF_W-1:0] merged;
	logic [CNT_W-1:0] total;
	logic             emit;
	block_t           block_next;

	logic             valid_q;
	sync_head_t       head_q;
	payload_t         data_q;

	always_comb begin
		// only the filled part of the residue is kept
		keep_mask = ~({BUF_W{1'b1}} << cnt_q);
		merged = (buf_q & keep_mask) | (BUF_W'(data_i) << cnt_q);
		total = cnt_q + CNT_W'(DATA_W);

		// slip drops the oldest buffered bit and moves the boundary by one
		if (slip_i) begin
			merged = merged >> 1;
			total = total - CNT_W'(1);
		end

		emit = (total >= CNT_W'(BLOCK_W));
		block_next = merged[BLOCK_W-1:0];

		if (emit) begin
			buf_next = merged >> BLOCK_W;
			cnt_next = total - CNT_W'(BLOCK_W);
		end else begin
			buf_next = merged;
			cnt_next = total;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cnt_q <= '0;
			valid_q <= 1'b0;
		end else begin
			cnt_q <= cnt_next;
			valid_q <= emit;
		end
	end

	// residue and output block registers
	always_ff @(posedge clk) begin
		buf_q <= buf_next;
		if (emit) begin
			head_q <= block_next.head;
			data_q <= block_next.data;
		end
	end

	assign valid_o = valid_q;
	assign head_o = head_q;
	assign data_o = data_q;

endmodule

//--- block_sync.sv
// sync header lock FSM with slip requests and windowed loss of lock
`include "pcs_rx_defs.svh"

module block_sync
	import pcs_rx_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,

	input  logic       blk_valid_i,
	input  sync_head_t head_i,

	output logic       slip_o,
	output logic       lock_o
);
	localparam int LOCK_GOOD = `PCS_LOCK_GOOD;
	localparam int BAD_MAX = `PCS_BAD_MAX;
	localparam int SLIP_WAIT = `PCS_SLIP_WAIT;
	localparam int WIN_LEN = 64;
	localparam int GOOD_W = $clog2(LOCK_GOOD + 1);
	localparam int BAD_W = $clog2(WIN_LEN + 1);
	localparam int WAIT_W = $clog2(SLIP_WAIT + 1);

	logic              lock_q;
	logic              slip_q;
	logic [GOOD_W-1:0] good_cnt_q;
	logic [WAIT_W-1:0] wait_cnt_q;

	// one flag per block in the sliding window, newest at bit 0
	logic [WIN_LEN-1:0] hist_q;
	logic [BAD_W-1:0]   bad_cnt_q;
	logic [BAD_W-1:0]   bad_cnt_next;
	logic               head_ok;

	always_comb begin
		head_ok = (head_i == HEAD_DATA) || (head_i == HEAD_CTRL);
		// newest block enters the window, oldest leaves
		bad_cnt_next = bad_cnt_q + BAD_W'(!head_ok) - BAD_W'(hist_q[WIN_LEN-1]);
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			lock_q <= 1'b0;
			slip_q <= 1'b0;
			good_cnt_q <= '0;
			wait_cnt_q <= '0;
			hist_q <= '0;
			bad_cnt_q <= '0;
		end else begin
			slip_q <= 1'b0;
			if (blk_valid_i) begin
				if (lock_q) begin
					hist_q <= {hist_q[WIN_LEN-2:0], !head_ok};
					bad_cnt_q <= bad_cnt_next;
					if (bad_cnt_next >= BAD_W'(BAD_MAX)) begin
						lock_q <= 1'b0;
						good_cnt_q <= '0;
					end
				end else if (wait_cnt_q != '0) begin
					// blocks still in flight from the old alignment
					wait_cnt_q <= wait_cnt_q - WAIT_W'(1);
				end else if (head_ok) begin
					if (good_cnt_q == GOOD_W'(LOCK_GOOD - 1)) begin
						lock_q <= 1'b1;
						hist_q <= '0;
						bad_cnt_q <= '0;
					end else begin
						good_cnt_q <= good_cnt_q + GOOD_W'(1);
					end
				end else begin
					slip_q <= 1'b1;
					good_cnt_q <= '0;
					wait_cnt_q <= WAIT_W'(SLIP_WAIT);
				end
			end
		end
	end

	assign slip_o = slip_q;
	assign lock_o = lock_q;

endmodule

//--- descrambler.sv
// self-synchronous x^58 + x^39 + 1 descrambler for the block payload
`include "pcs_rx_defs.svh"

module descrambler
	import pcs_rx_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,

	input  logic       valid_i,
	input  sync_head_t head_i,
	input  payload_t   data_i,

	output logic       valid_o,
	output sync_head_t head_o,
	output payload_t   data_o
);
	localparam int DATA_W = `PCS_DATA_W;
	localparam int SCR_LEN = `PCS_SCR_LEN;
	localparam int TAP_A = `PCS_SCR_TAP_A;
	localparam int TAP_B = `PCS_SCR_TAP_B;
	localparam int EXT_W = DATA_W + SCR_LEN;

	// last scrambled bits seen, most recent at the top
	logic [SCR_LEN-1:0] state_q;
	logic [EXT_W-1:0]   ext;
	payload_t           plain;

	logic               valid_q;
	sync_head_t         head_q;
	payload_t           data_q;

	always_comb begin
		ext = {data_i, state_q};
		for (int i = 0; i < DATA_W; i++) begin
			plain[i] = ext[i + SCR_LEN] ^ ext[i + SCR_LEN - TAP_A] ^ ext[i + SCR_LEN - TAP_B];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid_i;
		end
	end

	// state advances on every block, locked or not
	always_ff @(posedge clk) begin
		if (valid_i) begin
			state_q <= data_i[DATA_W-1 -: SCR_LEN];
			head_q <= head_i;
			data_q <= plain;
		end
	end

	assign valid_o = valid_q;
	assign head_o = head_q;
	assign data_o = data_q;

endmodule

//--- pcs_rx_top.sv
// pcs receive top with gearbox, block synchronizer and descrambler
module pcs_rx_top
	import pcs_rx_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,

	// serdes word, one per clock without gaps
	input  payload_t   data_i,

	output logic       block_valid_o,
	output sync_head_t head_o,
	output payload_t   data_o,
	output logic       lock_o
);
	logic       blk_valid;
	sync_head_t blk_head;
	payload_t   blk_data;
	logic       slip;

	gearbox_rx gearbox_rx_i (
		.clk     (clk),
		.rst_i   (rst_i),
		.data_i  (data_i),
		.slip_i  (slip),
		.valid_o (blk_valid),
		.head_o  (blk_head),
		.data_o  (blk_data)
	);

	// feedback loop, slip moves the gearbox boundary
	block_sync block_sync_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.blk_valid_i (blk_valid),
		.head_i      (blk_head),
		.slip_o      (slip),
		.lock_o      (lock_o)
	);

	descrambler descrambler_i (
		.clk     (clk),
		.rst_i   (rst_i),
		.valid_i (blk_valid),
		.head_i  (blk_head),
		.data_i  (blk_data),
		.valid_o (block_valid_o),
		.head_o  (head_o),
		.data_o  (data_o)
	);

endmodule

//--- pcs_rx_asserts.sv
// bound assertions on slip, block valid spacing and post-reset outputs of the pcs rx top
module pcs_rx_asserts (
	input logic clk,
	input logic rst_i,
	input logic slip_i,
	input logic lock_i,
	input logic block_valid_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// consecutive cycles with a valid block
	logic [5:0] high_run;

	always_ff @(posedge clk) begin
		if (rst_i || !block_valid_i) begin
			high_run <= '0;
		end else begin
			high_run <= high_run + 6'd1;
		end
	end

	slip_unlocked: assert property (@(posedge clk) disable iff (rst_i) lock_i |-> !slip_i)
		else $error("slip pulse seen while block lock is held");

	// gearbox leaves one empty cycle in every 33
	valid_gap: assert property (@(posedge clk) disable iff (rst_i) high_run <= 6'd33)
		else $error("block valid stayed high for 34 cycles or more");

	reset_idle: assert property (@(posedge clk) rst_i |=> (!lock_i && !block_valid_i))
		else $error("lock or block valid high in the cycle after reset");

endmodule

bind pcs_rx_top pcs_rx_asserts pcs_rx_asserts_i (
	.clk           (clk),
	.rst_i         (rst_i),
	.slip_i        (slip),
	.lock_i        (lock_o),
	.block_valid_i (block_valid_o)
);

//--- pcs_rx_tb.sv
// testbench for the pcs receive path, scrambled golden block stream with lock and payload checks
`include "pcs_rx_defs.svh"

module pcs_rx_tb
	import pcs_rx_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_GOLDEN = 16;
	localparam int RESET_CYCLES = 10;
	localparam int CHECK_BLOCKS = 200;
	localparam int RATE_CYCLES = 1000;
	// search, lock, payload checks, rate run, loss and relock, in blocks
	localparam int TOTAL_BLOCKS = 66 * (`PCS_SLIP_WAIT + 2) + 2 * `PCS_LOCK_GOOD
		+ 2 * CHECK_BLOCKS + RATE_CYCLES + `PCS_BAD_MAX;
	localparam int MAX_CYCLES = RESET_CYCLES + TOTAL_BLOCKS * 33 / 32 + 200;

	logic       clk;
	logic       rst_i;
	payload_t   serdes_word;
	logic       blk_valid;
	sync_head_t blk_head;
	payload_t   blk_data;
	logic       lock;

	logic [67:0] golden_mem [N_GOLDEN];
	sync_head_t  gold_head [N_GOLDEN];
	payload_t    gold_data [N_GOLDEN];

	bit                    stream_q [$];
	bit [`PCS_SCR_LEN-1:0] scr_hist;
	logic                  drive_en;
	int                    gen_idx;
	int                    corrupt_left;
	int                    junk_len;
	int                    cycle_cnt;
	string                 test_name;

	pcs_rx_top pcs_rx_top_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.data_i        (serdes_word),
		.block_valid_o (blk_valid),
		.head_o        (blk_head),
		.data_o        (blk_data),
		.lock_o        (lock)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// next golden block onto the line, header plain and payload scrambled
	function automatic void append_block();
		sync_head_t hd;
		payload_t   pl;
		bit         sbit;
		hd = gold_head[gen_idx];
		pl = gold_data[gen_idx];
		gen_idx = (gen_idx + 1) % N_GOLDEN;
		if (corrupt_left > 0) begin
			hd = 2'b00;
			corrupt_left--;
		end
		for (int i = 0; i < `PCS_HEAD_W; i++) begin
			stream_q.push_back(hd[i]);
		end
		// scr_hist[k] holds the scrambled bit sent k+1 positions earlier
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			sbit = pl[i] ^ scr_hist[`PCS_SCR_TAP_A-1] ^ scr_hist[`PCS_SCR_TAP_B-1];
			scr_hist = {scr_hist[`PCS_SCR_LEN-2:0], sbit};
			stream_q.push_back(sbit);
		end
	endfunction

	function automatic payload_t next_word();
		payload_t w;
		while (stream_q.size() < `PCS_DATA_W) begin
			append_block();
		end
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			w[i] = stream_q.pop_front();
		end
		return w;
	endfunction

	always @(posedge clk) begin
		if (drive_en) begin
			serdes_word <= next_word();
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			fail_now($sformatf("timeout after %0d cycles while running %s", cycle_cnt, test_name));
		end
	end

	task automatic load_golden();
		$readmemh("pcs_rx_golden.txt", golden_mem);
		for (int k = 0; k < N_GOLDEN; k++) begin
			gold_head[k] = golden_mem[k][65:64];
			gold_data[k] = golden_mem[k][63:0];
			assert (gold_head[k] == HEAD_DATA || gold_head[k] == HEAD_CTRL)
				else fail_now($sformatf("golden entry %0d is missing or has a bad header", k));
		end
	endtask

	task automatic check_idle();
		do begin
			@(negedge clk);
			assert (lock === 1'b0)
				else fail_now($sformatf("[ERROR] %s: lock expected 0 actual %b", test_name, lock));
		end while (blk_valid !== 1'b1);
	endtask

	task automatic wait_lock(input logic level);
		do begin
			@(negedge clk);
		end while (lock !== level);
	endtask

	// first block picks the golden entry, later ones follow it cyclically
	task automatic check_blocks(input int n);
		int idx;
		int seen;
		idx = -1;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (blk_valid === 1'b1) begin
				assert (lock === 1'b1)
					else fail_now($sformatf("[ERROR] %s: lock expected 1 actual %b", test_name, lock));
				if (idx < 0) begin
					for (int k = 0; k < N_GOLDEN; k++) begin
						if (idx < 0 && blk_head === gold_head[k] && blk_data === gold_data[k]) begin
							idx = k;
						end
					end
					assert (idx >= 0)
						else fail_now($sformatf("%s: first block %b %h matches no golden entry",
							test_name, blk_head, blk_data));
				end else begin
					idx = (idx + 1) % N_GOLDEN;
					assert ({blk_head, blk_data} === {gold_head[idx], gold_data[idx]})
						else fail_now($sformatf("[ERROR] %s: expected %b %h actual %b %h", test_name,
							gold_head[idx], gold_data[idx], blk_head, blk_data));
				end
				seen++;
			end
		end
	endtask

	task automatic check_rate(input int cycles);
		logic [32:0] hist;
		hist = '0;
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk);
			hist = {hist[31:0], blk_valid};
			assert (lock === 1'b1)
				else fail_now($sformatf("%s: lock dropped with a clean stream", test_name));
			if (c >= 32) begin
				assert ($countones(hist) == 32)
					else fail_now($sformatf("[ERROR] %s: blocks in 33 cycles expected 32 actual %0d",
						test_name, $countones(hist)));
			end
		end
	endtask

	initial begin
		void'($urandom(32'h261b));
		rst_i = 1'b1;
		serdes_word = '0;
		drive_en = 1'b0;
		gen_idx = 0;
		corrupt_left = 0;
		cycle_cnt = 0;
		test_name = "setup";
		load_golden();
		scr_hist = 58'({$urandom(), $urandom()});
		// random line offset ahead of the first block
		junk_len = $urandom_range(65, 0);
		for (int i = 0; i < junk_len; i++) begin
			stream_q.push_back(1'($urandom()));
		end

		repeat (RESET_CYCLES - 1) @(posedge clk);
		drive_en <= 1'b1;
		@(posedge clk);
		rst_i <= 1'b0;

		test_name = "reset_idle";
		check_idle();
		test_name = "lock_acquire";
		wait_lock(1'b1);
		test_name = "payload_check";
		check_blocks(CHECK_BLOCKS);
		test_name = "block_rate";
		check_rate(RATE_CYCLES);

		// consecutive bad headers, enough to drop lock
		test_name = "lock_loss";
		corrupt_left = `PCS_BAD_MAX;
		wait_lock(1'b0);
		test_name = "relock";
		wait_lock(1'b1);
		check_blocks(CHECK_BLOCKS);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- all.f
+incdir+.
pcs_rx_pkg.sv
gearbox_rx.sv
block_sync.sv
descrambler.sv
pcs_rx_top.sv
pcs_rx_asserts.sv
pcs_rx_tb.sv

//--- Makefile
# Verilator build and run for the pcs receive path
VERILATOR ?= verilator
TOP ?= pcs_rx_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG ?= Simulation PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) pcs_rx_defs.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- pcs_rx_golden.txt
// sync header digit (1 data, 2 control) then the 64-bit plaintext payload
// one block per line, sent in this order and repeated
10123456789abcdef
2fedcba9876543210
10000000000000000
1ffffffffffffffff
21e00000000000000
1a5a5a5a5a5a5a5a5
15a5a5a5a5a5a5a5a
278fdb3a500000000
13c3c0ff0a55a9669
10f0f0f0f0f0f0f0f
22d00000000000000
11122334455667788
18877665544332211
28700000000000000
113579bdf02468ace
1f0e1d2c3b4a59687
